// ==== verilog/tcdm_xbar_config.svh ====
// Global sizing macros for the TCDM logarithmic interconnect
// Counts, widths and address bit positions

`ifndef TCDM_XBAR_CONFIG_SVH
`define TCDM_XBAR_CONFIG_SVH

////////////////////
// Topology
////////////////////
`define TCDM_N_MASTER        4   // Masters on the request side
`define TCDM_N_BANK          4   // Word-interleaved banks

////////////////////
// Data path widths
////////////////////
`define TCDM_ADDR_WIDTH      32  // Master byte address
`define TCDM_DATA_WIDTH      32  // One bank word
`define TCDM_BE_WIDTH        4   // One enable per byte

// Address split: | bank word addr | bank sel | byte offset |
`define TCDM_BYTE_OFFSET     2   // Bits below the word
`define TCDM_BANK_SEL_WIDTH  2   // Interleave bits, just above the offset
`define TCDM_BANK_ADDR_WIDTH 8   // Word index inside one bank

`endif

// ==== verilog/tcdm_xbar_pkg.sv ====
// Shared types of the TCDM interconnect
// Payload types, one-hot ID and vector types, opcode enum

`include "tcdm_xbar_config.svh"

package tcdm_xbar_pkg;

    ////////////////////
    // Payload
    ////////////////////
    typedef logic [`TCDM_ADDR_WIDTH-1:0]      addr_t;       // Master byte address
    typedef logic [`TCDM_DATA_WIDTH-1:0]      data_t;       // Write or read word
    typedef logic [`TCDM_BE_WIDTH-1:0]        be_t;         // Byte enables
    typedef logic [`TCDM_BANK_ADDR_WIDTH-1:0] bank_addr_t;  // Word address in a bank
    typedef logic [`TCDM_BANK_SEL_WIDTH-1:0]  bank_sel_t;   // Bank index

    ////////////////////
    // Routing vectors
    ////////////////////
    // One-hot ID, bit m set for master m
    typedef logic [`TCDM_N_MASTER-1:0]        master_id_t;
    typedef logic [`TCDM_N_MASTER-1:0]        master_vec_t; // One bit per master
    typedef logic [`TCDM_N_BANK-1:0]          bank_vec_t;   // One bit per bank

    // Request type, same encoding as the wen line
    typedef enum logic
    {
        OP_STORE = 1'b0,  // wen low, write
        OP_LOAD  = 1'b1   // wen high, read
    } tcdm_op_e;

endpackage

// ==== verilog/tcdm_req_if.sv ====
// Decoded request bundle between master decoders and bank arbiters
// Grants travel back per bank

`timescale 1ns/1ps

`include "tcdm_xbar_config.svh"

interface tcdm_req_if;

    // Per master, written by its decoder
    tcdm_xbar_pkg::bank_vec_t   req_bank  [`TCDM_N_MASTER];  // At most one bit set
    tcdm_xbar_pkg::bank_addr_t  bank_addr [`TCDM_N_MASTER];  // Bank-local word address
    tcdm_xbar_pkg::tcdm_op_e    op        [`TCDM_N_MASTER];  // Load or store
    tcdm_xbar_pkg::data_t       wdata     [`TCDM_N_MASTER];
    tcdm_xbar_pkg::be_t         be        [`TCDM_N_MASTER];
    tcdm_xbar_pkg::master_id_t  id        [`TCDM_N_MASTER];  // One-hot source tag

    // Per bank, written by its arbiter
    tcdm_xbar_pkg::master_vec_t gnt       [`TCDM_N_BANK];    // Winner bit, at most one

    // Decoder side
    modport master
    (
        output req_bank,
        output bank_addr,
        output op,
        output wdata,
        output be,
        output id,
        input  gnt
    );

    // Arbiter side
    modport bank
    (
        input  req_bank,
        input  bank_addr,
        input  op,
        input  wdata,
        input  be,
        input  id,
        output gnt
    );

endinterface

// ==== verilog/tcdm_addr_decoder.sv ====
// Per-master address decoder
// Bank select, local word address, one-hot ID and grant return

`timescale 1ns/1ps

`include "tcdm_xbar_config.svh"

module tcdm_addr_decoder
#(
    parameter int unsigned MASTER_IDX = 0          // Position of this master
)
(
    input  logic                       req_i,      // Master request
    input  tcdm_xbar_pkg::addr_t       add_i,      // Byte address
    input  logic                       wen_i,      // 1 load, 0 store
    input  tcdm_xbar_pkg::data_t       wdata_i,
    input  tcdm_xbar_pkg::be_t         be_i,
    output logic                       gnt_o,      // Grant from the target bank

    tcdm_req_if.master                 req_if
);

    tcdm_xbar_pkg::bank_sel_t  bank_sel;   // Interleave bits of add_i
    tcdm_xbar_pkg::bank_vec_t  req_bank;   // One-hot target bank
    tcdm_xbar_pkg::bank_vec_t  gnt_vec;    // Our grant bit from each bank

    ////////////////////
    // Address split
    ////////////////////
    assign bank_sel = add_i[`TCDM_BYTE_OFFSET +: `TCDM_BANK_SEL_WIDTH];

    // Word index sits right above the bank bits
    assign req_if.bank_addr[MASTER_IDX] =
        add_i[`TCDM_BYTE_OFFSET + `TCDM_BANK_SEL_WIDTH +: `TCDM_BANK_ADDR_WIDTH];

    // Steer the request line to one bank only
    always_comb
    begin
        req_bank           = '0;
        req_bank[bank_sel] = req_i;    // Zero vector when idle
    end

    assign req_if.req_bank[MASTER_IDX] = req_bank;

    ////////////////////
    // Payload and tag
    ////////////////////
    assign req_if.op[MASTER_IDX]    = wen_i ? tcdm_xbar_pkg::OP_LOAD : tcdm_xbar_pkg::OP_STORE;
    assign req_if.wdata[MASTER_IDX] = wdata_i;
    assign req_if.be[MASTER_IDX]    = be_i;

    // ID is fixed by position
    assign req_if.id[MASTER_IDX]    = tcdm_xbar_pkg::master_id_t'(1) << MASTER_IDX;

    ////////////////////
    // Grant return
    ////////////////////
    for (genvar b = 0; b < `TCDM_N_BANK; b++)
    begin : g_gnt
        assign gnt_vec[b] = req_if.gnt[b][MASTER_IDX];  // Column of the grant matrix
    end

    // Only the selected bank can have granted us
    assign gnt_o = gnt_vec[bank_sel];

endmodule

// ==== verilog/tcdm_bank_arbiter.sv ====
// Per-bank round-robin arbiter with request multiplexer
// Grant-based flow control, pointer moves on each accepted transfer

`timescale 1ns/1ps

`include "tcdm_xbar_config.svh"

module tcdm_bank_arbiter
#(
    parameter int unsigned BANK_IDX = 0                // Bank served here
)
(
    input  logic                       clk,
    input  logic                       rst_n_i,

    tcdm_req_if.bank                   req_if,         // Decoded requests in, grants out

    input  logic                       gnt_i,          // Bank ready to accept
    output logic                       req_o,          // Any master targets this bank
    output tcdm_xbar_pkg::bank_addr_t  add_o,
    output logic                       wen_o,          // 1 load, 0 store
    output tcdm_xbar_pkg::data_t       wdata_o,
    output tcdm_xbar_pkg::be_t         be_o,
    output tcdm_xbar_pkg::master_id_t  id_o            // One-hot tag of the winner
);

    localparam int unsigned N_M   = `TCDM_N_MASTER;
    localparam int unsigned PTR_W = $clog2(`TCDM_N_MASTER);

    tcdm_xbar_pkg::master_vec_t req_vec;     // Masters aiming at this bank
    tcdm_xbar_pkg::master_vec_t gnt_vec;     // Winner bit when the bank accepts
    logic [PTR_W-1:0]           rr_ptr_q;    // Highest priority master
    logic [PTR_W-1:0]           rr_ptr_nxt;
    logic [PTR_W-1:0]           winner;
    logic                       winner_vld;

    ////////////////////
    // Request column
    ////////////////////
    for (genvar m = 0; m < N_M; m++)
    begin : g_req
        assign req_vec[m] = req_if.req_bank[m][BANK_IDX];
    end

    assign req_o = |req_vec;   // Held high under back-pressure too

    ////////////////////
    // Round-robin pick
    ////////////////////
    // Scan from the pointer upward, first requester wins
    always_comb
    begin
        logic [PTR_W-1:0] idx;

        winner     = rr_ptr_q;
        winner_vld = 1'b0;
        for (int unsigned k = 0; k < N_M; k++)
        begin
            idx = PTR_W'((int'(rr_ptr_q) + k) % N_M);   // Wrap around the ring
            if (!winner_vld && req_vec[idx])
            begin
                winner     = idx;
                winner_vld = 1'b1;
            end
        end
    end

    // Grant only when the bank takes it
    always_comb
    begin
        gnt_vec = '0;
        if (winner_vld && gnt_i)
        begin
            gnt_vec[winner] = 1'b1;
        end
    end

    assign req_if.gnt[BANK_IDX] = gnt_vec;

    ////////////////////
    // Payload mux
    ////////////////////
    assign add_o   = req_if.bank_addr[winner];
    assign wen_o   = (req_if.op[winner] == tcdm_xbar_pkg::OP_LOAD);
    assign wdata_o = req_if.wdata[winner];
    assign be_o    = req_if.be[winner];
    assign id_o    = req_if.id[winner];   // Returned by the bank with the response

    ////////////////////
    // Pointer update
    ////////////////////
    // One past the winner, wrapping at the last master
    assign rr_ptr_nxt = (winner == PTR_W'(N_M - 1)) ? '0 : winner + 1'b1;

    always_ff @(posedge clk or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            rr_ptr_q <= '0;
        end
        else if (req_o && gnt_i)
        begin
            rr_ptr_q <= rr_ptr_nxt;   // Stays put while the bank stalls
        end
    end

endmodule

// ==== verilog/tcdm_resp_router.sv ====
// Per-master response router
// Valid detection by one-hot ID and read data select

`timescale 1ns/1ps

`include "tcdm_xbar_config.svh"

module tcdm_resp_router
#(
    parameter int unsigned MASTER_IDX = 0                          // Master served here
)
(
    input  tcdm_xbar_pkg::bank_vec_t                      r_valid_i,  // Per bank
    input  tcdm_xbar_pkg::master_id_t [`TCDM_N_BANK-1:0]  r_id_i,     // Echoed request tags
    input  tcdm_xbar_pkg::data_t      [`TCDM_N_BANK-1:0]  r_rdata_i,
    output logic                                          r_valid_o,
    output tcdm_xbar_pkg::data_t                          r_rdata_o
);

    tcdm_xbar_pkg::bank_vec_t bank_hit;   // Banks answering this master

    ////////////////////
    // Match
    ////////////////////
    // Own ID bit set on a valid response
    for (genvar b = 0; b < `TCDM_N_BANK; b++)
    begin : g_hit
        assign bank_hit[b] = r_valid_i[b] & r_id_i[b][MASTER_IDX];
    end

    // Stores get a valid too
    assign r_valid_o = |bank_hit;

    ////////////////////
    // Data select
    ////////////////////
    // AND-OR mux, one grant per cycle leaves at most one hit
    always_comb
    begin
        r_rdata_o = '0;
        for (int unsigned b = 0; b < `TCDM_N_BANK; b++)
        begin
            r_rdata_o |= {`TCDM_DATA_WIDTH{bank_hit[b]}} & r_rdata_i[b];
        end
    end

endmodule

// ==== verilog/tcdm_xbar.sv ====
// Top level of the TCDM logarithmic interconnect
// Decoders per master, arbiters per bank, routers per master

`timescale 1ns/1ps

`include "tcdm_xbar_config.svh"

module tcdm_xbar
(
    input  logic                                             clk,
    input  logic                                             rst_n_i,

    // Master side
    input  logic                       [`TCDM_N_MASTER-1:0]  data_req_i,
    input  tcdm_xbar_pkg::addr_t       [`TCDM_N_MASTER-1:0]  data_add_i,
    input  logic                       [`TCDM_N_MASTER-1:0]  data_wen_i,     // 1 load, 0 store
    input  tcdm_xbar_pkg::data_t       [`TCDM_N_MASTER-1:0]  data_wdata_i,
    input  tcdm_xbar_pkg::be_t         [`TCDM_N_MASTER-1:0]  data_be_i,
    output logic                       [`TCDM_N_MASTER-1:0]  data_gnt_o,
    output logic                       [`TCDM_N_MASTER-1:0]  data_r_valid_o, // Loads and stores
    output tcdm_xbar_pkg::data_t       [`TCDM_N_MASTER-1:0]  data_r_rdata_o,

    // Bank side, word interleaved
    output logic                       [`TCDM_N_BANK-1:0]    data_req_o,
    output tcdm_xbar_pkg::bank_addr_t  [`TCDM_N_BANK-1:0]    data_add_o,
    output logic                       [`TCDM_N_BANK-1:0]    data_wen_o,
    output tcdm_xbar_pkg::data_t       [`TCDM_N_BANK-1:0]    data_wdata_o,
    output tcdm_xbar_pkg::be_t         [`TCDM_N_BANK-1:0]    data_be_o,
    output tcdm_xbar_pkg::master_id_t  [`TCDM_N_BANK-1:0]    data_id_o,      // One-hot source
    input  logic                       [`TCDM_N_BANK-1:0]    data_gnt_i,
    input  logic                       [`TCDM_N_BANK-1:0]    data_r_valid_i,
    input  tcdm_xbar_pkg::master_id_t  [`TCDM_N_BANK-1:0]    data_r_id_i,    // Echoed tag
    input  tcdm_xbar_pkg::data_t       [`TCDM_N_BANK-1:0]    data_r_rdata_i
);

    // Decoded requests and grant matrix
    tcdm_req_if req_if ();

    ////////////////////
    // Input side
    ////////////////////
    for (genvar m = 0; m < `TCDM_N_MASTER; m++)
    begin : g_dec
        tcdm_addr_decoder #(
            .MASTER_IDX ( m               )
        ) i_tcdm_addr_decoder (
            .req_i      ( data_req_i[m]   ),
            .add_i      ( data_add_i[m]   ),
            .wen_i      ( data_wen_i[m]   ),
            .wdata_i    ( data_wdata_i[m] ),
            .be_i       ( data_be_i[m]    ),
            .gnt_o      ( data_gnt_o[m]   ),
            .req_if     ( req_if.master   )
        );
    end

    ////////////////////
    // Bank arbitration
    ////////////////////
    for (genvar b = 0; b < `TCDM_N_BANK; b++)
    begin : g_arb
        tcdm_bank_arbiter #(
            .BANK_IDX ( b               )
        ) i_tcdm_bank_arbiter (
            .clk      ( clk             ),
            .rst_n_i  ( rst_n_i         ),
            .req_if   ( req_if.bank     ),
            .gnt_i    ( data_gnt_i[b]   ),
            .req_o    ( data_req_o[b]   ),
            .add_o    ( data_add_o[b]   ),
            .wen_o    ( data_wen_o[b]   ),
            .wdata_o  ( data_wdata_o[b] ),
            .be_o     ( data_be_o[b]    ),
            .id_o     ( data_id_o[b]    )
        );
    end

    ////////////////////
    // Output side
    ////////////////////
    // Every router sees all banks, filters by its own ID bit
    for (genvar m = 0; m < `TCDM_N_MASTER; m++)
    begin : g_rsp
        tcdm_resp_router #(
            .MASTER_IDX ( m                 )
        ) i_tcdm_resp_router (
            .r_valid_i  ( data_r_valid_i    ),
            .r_id_i     ( data_r_id_i       ),
            .r_rdata_i  ( data_r_rdata_i    ),
            .r_valid_o  ( data_r_valid_o[m] ),
            .r_rdata_o  ( data_r_rdata_o[m] )
        );
    end

endmodule

// ==== testbench/tcdm_xbar_sva.sv ====
// Concurrent assertions for one bank arbiter
// Bound into every tcdm_bank_arbiter instance

`timescale 1ns/1ps

module tcdm_xbar_sva
(
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  logic                       gnt_i,     // Bank accepts
    input  tcdm_xbar_pkg::master_vec_t req_vec,   // Masters aiming at this bank
    input  tcdm_xbar_pkg::master_vec_t gnt_vec    // Grant bits to masters
);

    ////////////////////
    // Grant shape
    ////////////////////
    // Never more than one winner
    a_gnt_onehot0 : assert property (
        @(posedge clk) disable iff (!rst_n_i)
        $onehot0(gnt_vec)
    ) else $error("bank arbiter granted more than one master");

    // A stalled bank grants nobody
    a_gnt_stall : assert property (
        @(posedge clk) disable iff (!rst_n_i)
        !gnt_i |-> (gnt_vec == '0)
    ) else $error("bank arbiter granted while the bank stalls");

    ////////////////////
    // Grant target
    ////////////////////
    a_gnt_req : assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (gnt_vec & ~req_vec) == '0
    ) else $error("bank arbiter granted a master that does not request it");

endmodule

// ==== testbench/tb_tcdm_xbar.sv ====
// Testbench for the TCDM interconnect
// Bank model, traffic driver, reference model, compare process, verdict

`timescale 1ns/1ps

`include "tcdm_xbar_config.svh"

module tb_tcdm_xbar;

    localparam int NM       = `TCDM_N_MASTER;
    localparam int NB       = `TCDM_N_BANK;
    localparam int SEL_LO   = `TCDM_BYTE_OFFSET;
    localparam int BADDR_LO = `TCDM_BYTE_OFFSET + `TCDM_BANK_SEL_WIDTH;
    localparam int WIDX_W   = `TCDM_BANK_SEL_WIDTH + `TCDM_BANK_ADDR_WIDTH;
    localparam int MAXQ     = 64;
    localparam int N_RR     = 8;      // Stores per master in the round-robin phase
    localparam int N_RAND   = 40;     // Random accesses per master
    localparam int N_BP     = 4;      // Accesses in the back-pressure phase
    localparam int N_TXN    = NM * N_RR + NM * N_RAND + N_BP;
    localparam int MAX_CYC  = N_TXN * 10 + 500;

    logic                                    clk;
    logic                                    rst_n_i;
    logic                       [NM-1:0]     data_req_i;
    tcdm_xbar_pkg::addr_t       [NM-1:0]     data_add_i;
    logic                       [NM-1:0]     data_wen_i;
    tcdm_xbar_pkg::data_t       [NM-1:0]     data_wdata_i;
    tcdm_xbar_pkg::be_t         [NM-1:0]     data_be_i;
    logic                       [NM-1:0]     data_gnt_o;
    logic                       [NM-1:0]     data_r_valid_o;
    tcdm_xbar_pkg::data_t       [NM-1:0]     data_r_rdata_o;
    logic                       [NB-1:0]     data_req_o;
    tcdm_xbar_pkg::bank_addr_t  [NB-1:0]     data_add_o;
    logic                       [NB-1:0]     data_wen_o;
    tcdm_xbar_pkg::data_t       [NB-1:0]     data_wdata_o;
    tcdm_xbar_pkg::be_t         [NB-1:0]     data_be_o;
    tcdm_xbar_pkg::master_id_t  [NB-1:0]     data_id_o;
    logic                       [NB-1:0]     data_gnt_i;
    logic                       [NB-1:0]     data_r_valid_i;
    tcdm_xbar_pkg::master_id_t  [NB-1:0]     data_r_id_i;
    tcdm_xbar_pkg::data_t       [NB-1:0]     data_r_rdata_i;

    // Per-master transaction lists
    tcdm_xbar_pkg::addr_t  txn_add   [NM][MAXQ];
    logic                  txn_wen   [NM][MAXQ];
    tcdm_xbar_pkg::data_t  txn_wdata [NM][MAXQ];
    tcdm_xbar_pkg::be_t    txn_be    [NM][MAXQ];
    int                    txn_cnt   [NM];
    int                    txn_pos   [NM];

    tcdm_xbar_pkg::data_t  bank_mem  [NB][2**`TCDM_BANK_ADDR_WIDTH];  // Bank contents
    tcdm_xbar_pkg::data_t  shadow    [2**WIDX_W];                      // Expected contents

    tcdm_xbar_pkg::master_vec_t due;            // Response expected this cycle
    tcdm_xbar_pkg::master_vec_t due_load;
    tcdm_xbar_pkg::data_t       exp_rdata [NM];

    integer seed = 99;
    int     gnt_mode;      // 0 always high, 1 random, 2 bank 1 stalled for a while
    int     bp_cnt;
    bit     bp_seen;       // A held request met a stalled bank
    bit     rr_check;
    int     rr_next;
    int     rr_cnt;
    int     cycle;
    int     err_data, err_id, err_bit, err_other;

    tcdm_xbar i_tcdm_xbar (.*);

    bind tcdm_bank_arbiter tcdm_xbar_sva i_tcdm_xbar_sva (
        .clk     ( clk     ),
        .rst_n_i ( rst_n_i ),
        .gnt_i   ( gnt_i   ),
        .req_vec ( req_vec ),
        .gnt_vec ( gnt_vec )
    );

    always #2 clk = ~clk;

    ////////////////////
    // Reference model
    ////////////////////
    function automatic tcdm_xbar_pkg::data_t fill_word(int unsigned idx);
        return tcdm_xbar_pkg::data_t'(32'hA5C3_0000 ^ (idx * 32'h0001_0101));  // Whole address
    endfunction

    // Byte-enabled write into an old word
    function automatic tcdm_xbar_pkg::data_t merge_bytes(tcdm_xbar_pkg::data_t old_w,
                                                         tcdm_xbar_pkg::data_t new_w,
                                                         tcdm_xbar_pkg::be_t be);
        tcdm_xbar_pkg::data_t res;
        res = old_w;
        for (int i = 0; i < `TCDM_BE_WIDTH; i++)
        begin
            if (be[i])
                res[8*i +: 8] = new_w[8*i +: 8];
        end
        return res;
    endfunction

    function automatic tcdm_xbar_pkg::data_t ref_read(int unsigned idx);
        return shadow[idx];
    endfunction

    function automatic tcdm_xbar_pkg::addr_t make_addr(int m, int k, int b);
        return (tcdm_xbar_pkg::addr_t'(m) << 10) | (tcdm_xbar_pkg::addr_t'(k) << BADDR_LO)
             | (tcdm_xbar_pkg::addr_t'(b) << SEL_LO);   // Master m owns its own range
    endfunction

    ////////////////////
    // Compare tasks
    ////////////////////
    task automatic check_data(string name, tcdm_xbar_pkg::data_t got, tcdm_xbar_pkg::data_t exp);
        if (got !== exp)
        begin
            err_data++;
            $display("ERR t=%0t %s got=%h exp=%h", $time, name, got, exp);
        end
    endtask

    task automatic check_id(string name, tcdm_xbar_pkg::master_id_t got,
                            tcdm_xbar_pkg::master_id_t exp);
        if (got !== exp)
        begin
            err_id++;
            $display("ERR t=%0t %s got=%b exp=%b", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp)
        begin
            err_bit++;
            $display("ERR t=%0t %s got=%b exp=%b", $time, name, got, exp);
        end
    endtask

    task automatic report_fail(string msg);
        err_other++;
        $display("Failure at %0t: %s", $time, msg);
    endtask

    ////////////////////
    // Bank model
    ////////////////////
    always @(posedge clk)
    begin
        #1;
        if (gnt_mode == 0)
            data_gnt_i = '1;
        else if (gnt_mode == 1)
        begin
            for (int b = 0; b < NB; b++)
                data_gnt_i[b] = (($random(seed) & 32'sd3) != 32'sd0);   // About 3/4 high
        end
        else
        begin
            data_gnt_i    = '1;
            data_gnt_i[1] = (bp_cnt >= 8);
            bp_cnt++;
        end
    end

    // Answer each accepted request one cycle later
    always @(posedge clk)
    begin : bank_proc
        logic [NB-1:0]             v;
        tcdm_xbar_pkg::master_id_t id [NB];
        tcdm_xbar_pkg::data_t      rd [NB];
        for (int b = 0; b < NB; b++)
        begin
            v[b]  = 1'b0;
            id[b] = '0;
            rd[b] = '0;
            if (rst_n_i && data_req_o[b] && data_gnt_i[b])
            begin
                v[b]  = 1'b1;
                id[b] = data_id_o[b];
                if (data_wen_o[b])
                    rd[b] = bank_mem[b][data_add_o[b]];
                else
                    bank_mem[b][data_add_o[b]] = merge_bytes(bank_mem[b][data_add_o[b]],
                                                             data_wdata_o[b], data_be_o[b]);
            end
        end
        #1;
        data_r_valid_i = v;
        for (int b = 0; b < NB; b++)
        begin
            data_r_id_i[b]    = id[b];
            data_r_rdata_i[b] = rd[b];
        end
    end

    ////////////////////
    // Compare process
    ////////////////////
    always @(posedge clk)
    begin : compare_proc
        tcdm_xbar_pkg::master_vec_t due_nxt;
        tcdm_xbar_pkg::master_id_t  exp_id;
        int                         sel;
        int                         nwin;
        int unsigned                idx;
        logic                       exp_req;
        if (!rst_n_i)
        begin
            due      = '0;
            due_load = '0;
        end
        else
        begin
            for (int m = 0; m < NM; m++)
            begin
                check_bit("data_r_valid_o", data_r_valid_o[m], due[m]);
                if (due[m] && due_load[m])
                    check_data("data_r_rdata_o", data_r_rdata_o[m], exp_rdata[m]);
            end
            for (int b = 0; b < NB; b++)
            begin
                exp_req = 1'b0;
                nwin    = 0;
                for (int m = 0; m < NM; m++)
                begin
                    sel = int'(data_add_i[m][SEL_LO +: `TCDM_BANK_SEL_WIDTH]);
                    if (data_req_i[m] && sel == b)
                        exp_req = 1'b1;
                    if (data_gnt_o[m] && sel == b)
                        nwin++;
                end
                check_bit("data_req_o", data_req_o[b], exp_req);
                if (data_req_o[b] && !data_gnt_i[b])
                    bp_seen = 1'b1;
                if ((data_req_o[b] && data_gnt_i[b]) != (nwin == 1))
                    report_fail($sformatf("bank %0d accepted without exactly one master grant",
                                          b));
            end
            due_nxt = '0;
            for (int m = 0; m < NM; m++)
            begin
                sel = int'(data_add_i[m][SEL_LO +: `TCDM_BANK_SEL_WIDTH]);
                if (data_gnt_o[m])
                begin
                    if (!data_req_i[m])
                        report_fail($sformatf("master %0d granted without a request", m));
                    if (!data_gnt_i[sel])
                        report_fail($sformatf("master %0d granted by a stalled bank", m));
                    exp_id    = '0;
                    exp_id[m] = 1'b1;   // One-hot tag of the issuing master
                    check_id("data_id_o", data_id_o[sel], exp_id);
                    check_data("data_add_o", 32'(data_add_o[sel]),
                               32'(data_add_i[m][BADDR_LO +: `TCDM_BANK_ADDR_WIDTH]));
                    check_bit("data_wen_o", data_wen_o[sel], data_wen_i[m]);
                    check_data("data_wdata_o", data_wdata_o[sel], data_wdata_i[m]);
                    check_data("data_be_o", 32'(data_be_o[sel]), 32'(data_be_i[m]));
                    due_nxt[m]  = 1'b1;
                    due_load[m] = data_wen_i[m];
                    idx = 32'(data_add_i[m][SEL_LO +: WIDX_W]);
                    if (data_wen_i[m])
                        exp_rdata[m] = ref_read(idx);
                    else
                        shadow[idx] = merge_bytes(shadow[idx], data_wdata_i[m], data_be_i[m]);
                    if (rr_check && sel == 0)
                    begin
                        if (m != rr_next)
                            report_fail($sformatf("round robin gave master %0d, expected %0d",
                                                  m, rr_next));
                        rr_next = (rr_next + 1) % NM;
                        rr_cnt++;
                    end
                end
            end
            due = due_nxt;
        end
    end

    // Run limit
    always @(posedge clk)
    begin
        cycle++;
        if (cycle > MAX_CYC)
        begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYC);
            $display(">>> FAIL");
            $finish;
        end
    end

    ////////////////////
    // Traffic driver
    ////////////////////
    task automatic push_txn(int m, tcdm_xbar_pkg::addr_t a, logic wen,
                            tcdm_xbar_pkg::data_t wd, tcdm_xbar_pkg::be_t be);
        txn_add[m][txn_cnt[m]]   = a;
        txn_wen[m][txn_cnt[m]]   = wen;
        txn_wdata[m][txn_cnt[m]] = wd;
        txn_be[m][txn_cnt[m]]    = be;
        txn_cnt[m]++;
    endtask

    // Each master holds its request until granted, then moves on
    task automatic run_traffic();
        bit busy;
        busy = 1'b1;
        while (busy)
        begin
            @(posedge clk);
            for (int m = 0; m < NM; m++)
            begin
                if (data_req_i[m] && data_gnt_o[m])
                    txn_pos[m]++;
            end
            #1;
            busy = 1'b0;
            for (int m = 0; m < NM; m++)
            begin
                if (txn_pos[m] < txn_cnt[m])
                begin
                    data_req_i[m]   = 1'b1;
                    data_add_i[m]   = txn_add[m][txn_pos[m]];
                    data_wen_i[m]   = txn_wen[m][txn_pos[m]];
                    data_wdata_i[m] = txn_wdata[m][txn_pos[m]];
                    data_be_i[m]    = txn_be[m][txn_pos[m]];
                    busy            = 1'b1;
                end
                else
                    data_req_i[m] = 1'b0;
            end
        end
        repeat (3) @(posedge clk);   // Drain responses
        for (int m = 0; m < NM; m++)
        begin
            txn_cnt[m] = 0;
            txn_pos[m] = 0;
        end
    endtask

    ////////////////////
    // Main sequence
    ////////////////////
    initial
    begin
        clk            = 1'b0;
        rst_n_i        = 1'b0;
        data_req_i     = '0;
        data_add_i     = '0;
        data_wen_i     = '0;
        data_wdata_i   = '0;
        data_be_i      = '0;
        data_gnt_i     = '1;
        data_r_valid_i = '0;
        data_r_id_i    = '0;
        data_r_rdata_i = '0;
        gnt_mode       = 0;
        bp_cnt         = 0;
        bp_seen        = 1'b0;
        rr_check       = 1'b0;
        rr_next        = 0;
        rr_cnt         = 0;
        cycle          = 0;
        err_data       = 0;
        err_id         = 0;
        err_bit        = 0;
        err_other      = 0;
        for (int m = 0; m < NM; m++)
        begin
            txn_cnt[m] = 0;
            txn_pos[m] = 0;
        end
        for (int b = 0; b < NB; b++)
        begin
            for (int a = 0; a < 2**`TCDM_BANK_ADDR_WIDTH; a++)
            begin
                bank_mem[b][a]      = fill_word(a * NB + b);
                shadow[a * NB + b]  = fill_word(a * NB + b);
            end
        end
        repeat (3) @(posedge clk);
        #1 rst_n_i = 1'b1;

        // All masters hammer bank 0, grants rotate from master 0
        rr_check = 1'b1;
        for (int m = 0; m < NM; m++)
            for (int k = 0; k < N_RR; k++)
                push_txn(m, make_addr(m, k, 0), 1'b0, data_t_rand(), 4'hF);
        run_traffic();
        rr_check = 1'b0;
        if (rr_cnt != NM * N_RR)
            report_fail("round robin phase did not see every grant");

        // Random mix under random bank stalls
        gnt_mode = 1;
        for (int m = 0; m < NM; m++)
            for (int n = 0; n < N_RAND; n++)
                push_txn(m, make_addr(m, int'($unsigned($random(seed)) % 32'd16),
                                      int'($unsigned($random(seed)) % 32'd4)),
                         1'($random(seed)), data_t_rand(), tcdm_xbar_pkg::be_t'($random(seed)));
        run_traffic();

        // Bank 1 stalls while two masters wait on it
        gnt_mode = 2;
        bp_cnt   = 0;
        bp_seen  = 1'b0;
        push_txn(0, make_addr(0, 3, 1), 1'b0, 32'h1234_5678, 4'b0101);
        push_txn(0, make_addr(0, 3, 1), 1'b1, '0, '0);
        push_txn(2, make_addr(2, 5, 1), 1'b0, 32'hCAFE_F00D, 4'b1110);
        push_txn(2, make_addr(2, 5, 1), 1'b1, '0, '0);
        run_traffic();
        if (!bp_seen)
            report_fail("back-pressure phase never saw a stalled request");

        $display("Errors: data %0d, id %0d, bit %0d, other %0d",
                 err_data, err_id, err_bit, err_other);
        if (err_data + err_id + err_bit + err_other == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

    function automatic tcdm_xbar_pkg::data_t data_t_rand();
        return tcdm_xbar_pkg::data_t'($random(seed));
    endfunction

endmodule

// ==== filelist.f ====
+incdir+verilog
verilog/tcdm_xbar_pkg.sv
verilog/tcdm_req_if.sv
verilog/tcdm_addr_decoder.sv
verilog/tcdm_bank_arbiter.sv
verilog/tcdm_resp_router.sv
verilog/tcdm_xbar.sv
testbench/tcdm_xbar_sva.sv
testbench/tb_tcdm_xbar.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the interconnect testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f filelist.f \
    --top-module tb_tcdm_xbar \
    -o sim_tb

out=$(./obj_dir/sim_tb)
echo "$out"

if echo "$out" | grep -qx '>>> PASS'; then
    exit 0
else
    exit 1
fi
